//--- include/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data word width of the integer datapath
`define MIPS_XLEN 32

// Width of a register number (32 architectural registers)
`define MIPS_REG_W 5

// Restoring divider produces one quotient bit per cycle
`define MIPS_DIV_STEPS 32

`endif

//--- hdl/mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

  typedef logic [`MIPS_XLEN-1:0] word_t;
  typedef logic [`MIPS_REG_W-1:0] reg_idx_t;

  // Primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f
  } opcode_t;

  // Function field of SPECIAL instructions, bits 5:0
  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_SRA   = 6'h03,
    FUNC_SLLV  = 6'h04,
    FUNC_SRLV  = 6'h06,
    FUNC_SRAV  = 6'h07,
    FUNC_MFHI  = 6'h10,
    FUNC_MFLO  = 6'h12,
    FUNC_MULT  = 6'h18,
    FUNC_MULTU = 6'h19,
    FUNC_DIV   = 6'h1a,
    FUNC_DIVU  = 6'h1b,
    FUNC_ADD   = 6'h20,
    FUNC_ADDU  = 6'h21,
    FUNC_SUB   = 6'h22,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_NOR   = 6'h27,
    FUNC_SLT   = 6'h2a,
    FUNC_SLTU  = 6'h2b
  } func_t;

  typedef struct packed {
    opcode_t    opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    func_t      funct;
  } instr_r_t;

  typedef struct packed {
    opcode_t     opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm16;
  } instr_i_t;

  // Same instruction word seen as R-type or I-type
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_ADD, ALU_SUB, ALU_AND,
    ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
  } alu_op_t;

  typedef enum logic [2:0] {
    MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU, MD_MFHI, MD_MFLO
  } md_op_t;

  typedef struct packed {
    alu_op_t    alu_op;
    logic       use_imm;
    logic       imm_signed;
    logic       shamt_var;
    logic [4:0] shamt;
    reg_idx_t   dest;
    logic       wr_en;
    logic       trap_ovf;
    md_op_t     md_op;
  } dec_ctrl_t;

  typedef struct packed {
    word_t value;
    logic  ovf;
  } alu_res_t;

  typedef struct packed {
    reg_idx_t idx;
    word_t    data;
  } wb_t;

endpackage

//--- hdl/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
  input  mips_pkg::instr_u    instr_i,
  output mips_pkg::dec_ctrl_t ctrl_o
);
  import mips_pkg::*;

  always_comb begin
    // Safe defaults, nothing is written
    ctrl_o.alu_op     = ALU_ADD;
    ctrl_o.use_imm    = 1'b0;
    ctrl_o.imm_signed = 1'b0;
    ctrl_o.shamt_var  = 1'b0;
    ctrl_o.shamt      = instr_i.r.shamt;
    ctrl_o.dest       = instr_i.r.rd;
    ctrl_o.wr_en      = 1'b0;
    ctrl_o.trap_ovf   = 1'b0;
    ctrl_o.md_op      = MD_NONE;

    if (instr_i.r.opcode == OP_SPECIAL) begin
      ctrl_o.wr_en = 1'b1;
      case (instr_i.r.funct)
        FUNC_SLL:  ctrl_o.alu_op = ALU_SLL;
        FUNC_SRL:  ctrl_o.alu_op = ALU_SRL;
        FUNC_SRA:  ctrl_o.alu_op = ALU_SRA;
        FUNC_SLLV: begin
          ctrl_o.alu_op    = ALU_SLL;
          ctrl_o.shamt_var = 1'b1;
        end
        FUNC_SRLV: begin
          ctrl_o.alu_op    = ALU_SRL;
          ctrl_o.shamt_var = 1'b1;
        end
        FUNC_SRAV: begin
          ctrl_o.alu_op    = ALU_SRA;
          ctrl_o.shamt_var = 1'b1;
        end
        FUNC_ADD: begin
          ctrl_o.alu_op   = ALU_ADD;
          ctrl_o.trap_ovf = 1'b1;
        end
        FUNC_ADDU: ctrl_o.alu_op = ALU_ADD;
        FUNC_SUB: begin
          ctrl_o.alu_op   = ALU_SUB;
          ctrl_o.trap_ovf = 1'b1;
        end
        FUNC_SUBU: ctrl_o.alu_op = ALU_SUB;
        FUNC_AND:  ctrl_o.alu_op = ALU_AND;
        FUNC_OR:   ctrl_o.alu_op = ALU_OR;
        FUNC_XOR:  ctrl_o.alu_op = ALU_XOR;
        FUNC_NOR:  ctrl_o.alu_op = ALU_NOR;
        FUNC_SLT:  ctrl_o.alu_op = ALU_SLT;
        FUNC_SLTU: ctrl_o.alu_op = ALU_SLTU;
        FUNC_MFHI: ctrl_o.md_op = MD_MFHI;
        FUNC_MFLO: ctrl_o.md_op = MD_MFLO;
        // HI/LO writers have no register destination
        FUNC_MULT: begin
          ctrl_o.md_op = MD_MULT;
          ctrl_o.wr_en = 1'b0;
        end
        FUNC_MULTU: begin
          ctrl_o.md_op = MD_MULTU;
          ctrl_o.wr_en = 1'b0;
        end
        FUNC_DIV: begin
          ctrl_o.md_op = MD_DIV;
          ctrl_o.wr_en = 1'b0;
        end
        FUNC_DIVU: begin
          ctrl_o.md_op = MD_DIVU;
          ctrl_o.wr_en = 1'b0;
        end
        default: ctrl_o.wr_en = 1'b0;
      endcase
    end else begin
      // I-type, result goes to rt
      ctrl_o.dest    = instr_i.i.rt;
      ctrl_o.use_imm = 1'b1;
      ctrl_o.wr_en   = 1'b1;
      case (instr_i.i.opcode)
        OP_ADDI: begin
          ctrl_o.imm_signed = 1'b1;
          ctrl_o.trap_ovf   = 1'b1;
        end
        OP_ADDIU: ctrl_o.imm_signed = 1'b1;
        OP_SLTI: begin
          ctrl_o.alu_op     = ALU_SLT;
          ctrl_o.imm_signed = 1'b1;
        end
        // Immediate is sign extended, then compared unsigned
        OP_SLTIU: begin
          ctrl_o.alu_op     = ALU_SLTU;
          ctrl_o.imm_signed = 1'b1;
        end
        OP_ANDI: ctrl_o.alu_op = ALU_AND;
        OP_ORI:  ctrl_o.alu_op = ALU_OR;
        OP_XORI: ctrl_o.alu_op = ALU_XOR;
        OP_LUI:  ctrl_o.alu_op = ALU_LUI;
        default: ctrl_o.wr_en = 1'b0;
      endcase
    end
  end

endmodule

//--- hdl/int_alu.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module int_alu (
  input  mips_pkg::dec_ctrl_t ctrl_i,
  input  logic [15:0]         imm_i,
  input  mips_pkg::word_t     rs_i,
  input  mips_pkg::word_t     rt_i,
  output mips_pkg::alu_res_t  res_o
);
  import mips_pkg::*;

  word_t      imm_ext;
  word_t      opb;
  logic [4:0] shift_amt;
  word_t      sum;
  word_t      diff;
  logic       sum_ovf;
  logic       diff_ovf;
  logic       lt_signed;
  logic       lt_unsigned;
  word_t      value;
  logic       ovf;

  assign imm_ext = ctrl_i.imm_signed ? {{(`MIPS_XLEN-16){imm_i[15]}}, imm_i}
                                     : {{(`MIPS_XLEN-16){1'b0}}, imm_i};

  assign opb = ctrl_i.use_imm ? imm_ext : rt_i;

  // Variable shifts use the low five bits of rs
  assign shift_amt = ctrl_i.shamt_var ? rs_i[4:0] : ctrl_i.shamt;

  assign sum  = rs_i + opb;
  assign diff = rs_i - opb;

  // Signed overflow: operands agree in sign, result does not
  assign sum_ovf = (rs_i[`MIPS_XLEN-1] == opb[`MIPS_XLEN-1]) &&
                   (sum[`MIPS_XLEN-1] != rs_i[`MIPS_XLEN-1]);
  assign diff_ovf = (rs_i[`MIPS_XLEN-1] != opb[`MIPS_XLEN-1]) &&
                    (diff[`MIPS_XLEN-1] != rs_i[`MIPS_XLEN-1]);

  assign lt_signed   = $signed(rs_i) < $signed(opb);
  assign lt_unsigned = rs_i < opb;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_SLL:  value = rt_i << shift_amt;
      ALU_SRL:  value = rt_i >> shift_amt;
      ALU_SRA:  value = $signed(rt_i) >>> shift_amt;
      ALU_ADD:  value = sum;
      ALU_SUB:  value = diff;
      ALU_AND:  value = rs_i & opb;
      ALU_OR:   value = rs_i | opb;
      ALU_XOR:  value = rs_i ^ opb;
      ALU_NOR:  value = ~(rs_i | opb);
      ALU_SLT:  value = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: value = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};
      // Upper half from the immediate, zeros below
      ALU_LUI:  value = {imm_i, 16'h0000};
      default:  value = sum;
    endcase
  end

  // Only the trapping forms report overflow
  always_comb begin
    ovf = 1'b0;
    if (ctrl_i.trap_ovf) begin
      if (ctrl_i.alu_op == ALU_ADD) begin
        ovf = sum_ovf;
      end else if (ctrl_i.alu_op == ALU_SUB) begin
        ovf = diff_ovf;
      end
    end
  end

  assign res_o.value = value;
  assign res_o.ovf   = ovf;

endmodule

//--- hdl/muldiv_unit.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module muldiv_unit (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                start_i,
  input  mips_pkg::md_op_t    op_i,
  input  mips_pkg::word_t     rs_i,
  input  mips_pkg::word_t     rt_i,
  output mips_pkg::word_t     hi_o,
  output mips_pkg::word_t     lo_o,
  output logic                busy_o
);
  import mips_pkg::*;

  word_t                              hi_q;
  word_t                              lo_q;
  logic                               busy_q;
  logic [$clog2(`MIPS_DIV_STEPS)-1:0] step_q;
  word_t                              rem_q;
  word_t                              quo_q;
  word_t                              dvsr_q;
  logic                               neg_quo_q;
  logic                               neg_rem_q;
  logic                               div_start;
  logic                               a_neg;
  logic                               b_neg;
  word_t                              a_mag;
  word_t                              b_mag;
  logic signed [2*`MIPS_XLEN-1:0]     prod_s;
  logic [2*`MIPS_XLEN-1:0]            prod_u;
  logic [`MIPS_XLEN:0]                rem_shift;
  logic [`MIPS_XLEN:0]                rem_sub;
  logic                               q_bit;
  word_t                              rem_next;
  word_t                              quo_next;
  logic                               last_step;

  assign prod_s = $signed(rs_i) * $signed(rt_i);
  assign prod_u = {{`MIPS_XLEN{1'b0}}, rs_i} * {{`MIPS_XLEN{1'b0}}, rt_i};

  assign div_start = start_i && (op_i == MD_DIV || op_i == MD_DIVU);

  // Divider runs on magnitudes, signs are restored at the end
  assign a_neg = (op_i == MD_DIV) && rs_i[`MIPS_XLEN-1];
  assign b_neg = (op_i == MD_DIV) && rt_i[`MIPS_XLEN-1];
  assign a_mag = a_neg ? -rs_i : rs_i;
  assign b_mag = b_neg ? -rt_i : rt_i;

  // One restoring step, shift in the next dividend bit and try subtract
  assign rem_shift = {rem_q, quo_q[`MIPS_XLEN-1]};
  assign rem_sub   = rem_shift - {1'b0, dvsr_q};
  assign q_bit     = rem_shift >= {1'b0, dvsr_q};
  assign rem_next  = q_bit ? rem_sub[`MIPS_XLEN-1:0] : rem_shift[`MIPS_XLEN-1:0];
  assign quo_next  = {quo_q[`MIPS_XLEN-2:0], q_bit};

  assign last_step = busy_q && (int'(step_q) == `MIPS_DIV_STEPS - 1);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      step_q <= '0;
    end else if (div_start) begin
      busy_q <= 1'b1;
      step_q <= '0;
    end else if (busy_q) begin
      step_q <= step_q + 1'b1;
      if (last_step) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (div_start) begin
      rem_q     <= '0;
      quo_q     <= a_mag;
      dvsr_q    <= b_mag;
      neg_quo_q <= a_neg ^ b_neg;
      neg_rem_q <= a_neg;
    end else if (busy_q) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (start_i && op_i == MD_MULT) begin
      {hi_q, lo_q} <= prod_s;
    end else if (start_i && op_i == MD_MULTU) begin
      {hi_q, lo_q} <= prod_u;
    end else if (last_step) begin
      // Remainder follows the dividend sign
      hi_q <= neg_rem_q ? -rem_next : rem_next;
      lo_q <= neg_quo_q ? -quo_next : quo_next;
    end
  end

  assign hi_o   = hi_q;
  assign lo_o   = lo_q;
  assign busy_o = busy_q;

endmodule

//--- hdl/result_select.sv
`timescale 1ns/10ps

module result_select (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                issue_i,
  input  mips_pkg::dec_ctrl_t ctrl_i,
  input  mips_pkg::alu_res_t  alu_i,
  input  mips_pkg::word_t     hi_i,
  input  mips_pkg::word_t     lo_i,
  output logic                wb_valid_o,
  output mips_pkg::wb_t       wb_o,
  output logic                ovf_o
);
  import mips_pkg::*;

  word_t wb_data;
  logic  wb_fire;

  always_comb begin
    case (ctrl_i.md_op)
      MD_MFHI: wb_data = hi_i;
      MD_MFLO: wb_data = lo_i;
      default: wb_data = alu_i.value;
    endcase
  end

  // Register 0 is never reported, and a trap cancels the write
  assign wb_fire = issue_i && ctrl_i.wr_en && (ctrl_i.dest != '0) && !alu_i.ovf;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_o <= 1'b0;
      ovf_o      <= 1'b0;
    end else begin
      wb_valid_o <= wb_fire;
      ovf_o      <= issue_i && alu_i.ovf;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_i) begin
      wb_o.idx  <= ctrl_i.dest;
      wb_o.data <= wb_data;
    end
  end

endmodule

//--- hdl/mips_exec_top.sv
`timescale 1ns/10ps

module mips_exec_top (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             instr_valid_i,
  input  mips_pkg::instr_u instr_i,
  input  mips_pkg::word_t  rs_val_i,
  input  mips_pkg::word_t  rt_val_i,
  output logic             wb_valid_o,
  output mips_pkg::wb_t    wb_o,
  output logic             ovf_o,
  output logic             busy_o
);
  import mips_pkg::*;

  dec_ctrl_t ctrl;
  alu_res_t  alu_res;
  word_t     hi;
  word_t     lo;
  logic      issue;

  // Strobes that arrive during a divide are dropped
  assign issue = instr_valid_i && !busy_o;

  instr_decode u_instr_decode (
    .instr_i (instr_i),
    .ctrl_o  (ctrl)
  );

  int_alu u_int_alu (
    .ctrl_i (ctrl),
    .imm_i  (instr_i.i.imm16),
    .rs_i   (rs_val_i),
    .rt_i   (rt_val_i),
    .res_o  (alu_res)
  );

  muldiv_unit u_muldiv_unit (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .start_i  (issue),
    .op_i     (ctrl.md_op),
    .rs_i     (rs_val_i),
    .rt_i     (rt_val_i),
    .hi_o     (hi),
    .lo_o     (lo),
    .busy_o   (busy_o)
  );

  result_select u_result_select (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .issue_i    (issue),
    .ctrl_i     (ctrl),
    .alu_i      (alu_res),
    .hi_i       (hi),
    .lo_i       (lo),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o),
    .ovf_o      (ovf_o)
  );

endmodule

//--- testbench/tb_mips_exec.sv
`timescale 1ns/10ps
`include "mips_params.svh"

module tb_mips_exec;
  import mips_pkg::*;

  // Instructions issued over all tests, sizes the watchdog
  localparam int NUM_INSTR = 185;

  localparam logic [5:0] R_FUNCS [16] = '{
    FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV, FUNC_SRAV, FUNC_ADD, FUNC_ADDU,
    FUNC_SUB, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_SLTU
  };
  localparam logic [5:0] I_OPS [8] = '{
    OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
  };

  logic   clk;
  logic   arst_n_i;
  logic   instr_valid_i;
  instr_u instr_i;
  word_t  rs_val_i;
  word_t  rt_val_i;
  logic   wb_valid_o;
  wb_t    wb_o;
  logic   ovf_o;
  logic   busy_o;

  // Reference copy of the HI/LO pair
  word_t hi_m;
  word_t lo_m;

  mips_exec_top u_mips_exec_top (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rs_val_i      (rs_val_i),
    .rt_val_i      (rt_val_i),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o),
    .ovf_o         (ovf_o),
    .busy_o        (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #((NUM_INSTR * 40 + 200) * 10);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Something failed");
    $fatal(1);
  end

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic word_t enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [4:0] rd,
                                  input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input logic [4:0] rs,
                                  input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Expected {overflow, value} of an ALU instruction
  function automatic logic [32:0] alu_model(input word_t word, input word_t a, input word_t b);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [4:0]  sh;
    word_t       sext;
    word_t       zext;
    logic [32:0] wide;
    word_t       v;
    logic        ovf;
    op   = word[31:26];
    fn   = word[5:0];
    sh   = word[10:6];
    sext = {{16{word[15]}}, word[15:0]};
    zext = {16'h0000, word[15:0]};
    v    = '0;
    ovf  = 1'b0;
    wide = '0;
    if (op == OP_SPECIAL) begin
      case (fn)
        FUNC_SLL:  v = b << sh;
        FUNC_SRL:  v = b >> sh;
        FUNC_SRA:  v = word_t'($signed(b) >>> sh);
        FUNC_SLLV: v = b << a[4:0];
        FUNC_SRLV: v = b >> a[4:0];
        FUNC_SRAV: v = word_t'($signed(b) >>> a[4:0]);
        FUNC_ADD, FUNC_ADDU: begin
          wide = {a[31], a} + {b[31], b};
          v    = wide[31:0];
          ovf  = (fn == FUNC_ADD) && (wide[32] != wide[31]);
        end
        FUNC_SUB, FUNC_SUBU: begin
          wide = {a[31], a} - {b[31], b};
          v    = wide[31:0];
          ovf  = (fn == FUNC_SUB) && (wide[32] != wide[31]);
        end
        FUNC_AND:  v = a & b;
        FUNC_OR:   v = a | b;
        FUNC_XOR:  v = a ^ b;
        FUNC_NOR:  v = ~(a | b);
        FUNC_SLT:  v = {31'd0, $signed(a) < $signed(b)};
        FUNC_SLTU: v = {31'd0, a < b};
        default:   v = '0;
      endcase
    end else begin
      case (op)
        OP_ADDI, OP_ADDIU: begin
          wide = {a[31], a} + {sext[31], sext};
          v    = wide[31:0];
          ovf  = (op == OP_ADDI) && (wide[32] != wide[31]);
        end
        OP_SLTI:  v = {31'd0, $signed(a) < $signed(sext)};
        OP_SLTIU: v = {31'd0, a < sext};
        OP_ANDI:  v = a & zext;
        OP_ORI:   v = a | zext;
        OP_XORI:  v = a ^ zext;
        OP_LUI:   v = {word[15:0], 16'h0000};
        default:  v = '0;
      endcase
    end
    return {ovf, v};
  endfunction

  // One strobe, then wait until the registered outputs have settled
  task automatic drive_instr(input word_t word, input word_t a, input word_t b);
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    rs_val_i      <= a;
    rt_val_i      <= b;
    @(posedge clk);
    instr_valid_i <= 1'b0;
    @(negedge clk);
  endtask

  task automatic run_alu(input word_t word, input word_t a, input word_t b,
                         input logic [4:0] dest);
    logic [32:0] model;
    model = alu_model(word, a, b);
    drive_instr(word, a, b);
    check("ovf_o", ovf_o, model[32]);
    if (model[32] || dest == 5'd0) begin
      check("wb_valid_o without write", wb_valid_o, 1'b0);
    end else begin
      check("wb_valid_o", wb_valid_o, 1'b1);
      check("wb_o.idx", wb_o.idx, dest);
      check("wb_o.data", wb_o.data, model[31:0]);
    end
  endtask

  task automatic read_hilo();
    drive_instr(enc_r(FUNC_MFHI, 5'd0, 5'd0, 5'd2, 5'd0), '0, '0);
    check("MFHI wb_valid_o", wb_valid_o, 1'b1);
    check("MFHI wb_o.idx", wb_o.idx, 5'd2);
    check("MFHI value", wb_o.data, hi_m);
    drive_instr(enc_r(FUNC_MFLO, 5'd0, 5'd0, 5'd3, 5'd0), '0, '0);
    check("MFLO wb_valid_o", wb_valid_o, 1'b1);
    check("MFLO wb_o.idx", wb_o.idx, 5'd3);
    check("MFLO value", wb_o.data, lo_m);
  endtask

  task automatic run_div(input logic [5:0] fn, input word_t a, input word_t b, input bit stray);
    int cycles;
    drive_instr(enc_r(fn, 5'd1, 5'd2, 5'd0, 5'd0), a, b);
    cycles = 0;
    while (busy_o) begin
      cycles++;
      check("wb_valid_o during divide", wb_valid_o, 1'b0);
      if (cycles > 4 * `MIPS_DIV_STEPS) begin
        $display("The divider stayed busy far beyond its step count");
        $display("Something failed");
        $fatal(1);
      end
      @(posedge clk);
      // A divide sent while busy must not restart the divider or touch HI/LO
      if (stray && cycles == 4) begin
        instr_valid_i <= 1'b1;
        instr_i       <= enc_r(FUNC_DIVU, 5'd1, 5'd2, 5'd0, 5'd0);
        rs_val_i      <= 32'hffffffff;
        rt_val_i      <= 32'h00000001;
      end else begin
        instr_valid_i <= 1'b0;
      end
      @(negedge clk);
    end
    check("busy_o cycle count", cycles, `MIPS_DIV_STEPS);
  endtask

  task automatic test_reset_idle();
    check("wb_valid_o after reset", wb_valid_o, 1'b0);
    check("ovf_o after reset", ovf_o, 1'b0);
    check("busy_o after reset", busy_o, 1'b0);
    read_hilo();
  endtask

  task automatic test_rtype_alu();
    word_t      a;
    word_t      b;
    logic [4:0] rd;
    logic [4:0] sh;
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 4; k++) begin
        a  = $urandom();
        b  = $urandom();
        rd = 5'(1 + $urandom() % 31);
        sh = 5'($urandom());
        run_alu(enc_r(R_FUNCS[i], 5'd1, 5'd2, rd, sh), a, b, rd);
      end
    end
    // Register 0 as destination
    a = $urandom();
    b = $urandom();
    run_alu(enc_r(FUNC_ADDU, 5'd1, 5'd2, 5'd0, 5'd0), a, b, 5'd0);
  endtask

  task automatic test_itype_alu();
    word_t       a;
    word_t       b;
    logic [4:0]  rt;
    logic [15:0] imm;
    for (int i = 0; i < 8; i++) begin
      for (int k = 0; k < 4; k++) begin
        a   = $urandom();
        b   = $urandom();
        rt  = 5'(1 + $urandom() % 31);
        imm = {k[0], 15'($urandom())};
        run_alu(enc_i(I_OPS[i], 5'd4, rt, imm), a, b, rt);
      end
    end
  endtask

  task automatic test_overflow();
    word_t       add_a [2] = '{32'h7fffffff, 32'h80000000};
    word_t       add_b [2] = '{32'h00000001, 32'hffffffff};
    word_t       sub_a [2] = '{32'h80000000, 32'h7fffffff};
    word_t       sub_b [2] = '{32'h00000001, 32'hffffffff};
    logic [15:0] imms  [2] = '{16'h0001, 16'hffff};
    for (int j = 0; j < 2; j++) begin
      run_alu(enc_r(FUNC_ADD, 5'd1, 5'd2, 5'd7, 5'd0), add_a[j], add_b[j], 5'd7);
      check("ADD overflow pulse", ovf_o, 1'b1);
      run_alu(enc_r(FUNC_ADDU, 5'd1, 5'd2, 5'd7, 5'd0), add_a[j], add_b[j], 5'd7);
      run_alu(enc_r(FUNC_SUB, 5'd1, 5'd2, 5'd8, 5'd0), sub_a[j], sub_b[j], 5'd8);
      check("SUB overflow pulse", ovf_o, 1'b1);
      run_alu(enc_r(FUNC_SUBU, 5'd1, 5'd2, 5'd8, 5'd0), sub_a[j], sub_b[j], 5'd8);
      run_alu(enc_i(OP_ADDI, 5'd1, 5'd9, imms[j]), add_a[j], '0, 5'd9);
      check("ADDI overflow pulse", ovf_o, 1'b1);
      run_alu(enc_i(OP_ADDIU, 5'd1, 5'd9, imms[j]), add_a[j], '0, 5'd9);
    end
  endtask

  task automatic test_multiply();
    word_t       ma [6];
    word_t       mb [6];
    logic [63:0] prod;
    for (int i = 0; i < 3; i++) begin
      ma[i] = $urandom();
      mb[i] = $urandom();
    end
    ma[3] = 32'h80000000;
    mb[3] = 32'h80000000;
    ma[4] = 32'hffffffff;
    mb[4] = 32'hffffffff;
    ma[5] = 32'h7fffffff;
    mb[5] = 32'h80000000;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 6; i++) begin
        // Signed product as the low 64 bits of the sign-extended operands
        if (s == 0) begin
          prod = {{32{ma[i][31]}}, ma[i]} * {{32{mb[i][31]}}, mb[i]};
        end else begin
          prod = {32'h0, ma[i]} * {32'h0, mb[i]};
        end
        drive_instr(enc_r(s == 0 ? FUNC_MULT : FUNC_MULTU, 5'd1, 5'd2, 5'd0, 5'd0),
                    ma[i], mb[i]);
        check("multiply wb_valid_o", wb_valid_o, 1'b0);
        hi_m = prod[63:32];
        lo_m = prod[31:0];
        read_hilo();
      end
    end
  endtask

  task automatic test_divide();
    word_t da [6] = '{32'd100, -32'd100, 32'd100, -32'd100, 32'hdeadbeef, 32'hfffffff0};
    word_t db [6] = '{32'd7, 32'd7, -32'd7, -32'd7, 32'd0, 32'd0};
    word_t am;
    word_t bm;
    word_t qm;
    word_t rm;
    logic  an;
    logic  bn;
    for (int s = 0; s < 2; s++) begin
      for (int i = 0; i < 6; i++) begin
        an = (s == 0) && da[i][31];
        bn = (s == 0) && db[i][31];
        am = an ? -da[i] : da[i];
        bm = bn ? -db[i] : db[i];
        if (bm == '0) begin
          qm = '1;
          rm = am;
        end else begin
          qm = am / bm;
          rm = am % bm;
        end
        lo_m = (an ^ bn) ? -qm : qm;
        hi_m = an ? -rm : rm;
        run_div(s == 0 ? FUNC_DIV : FUNC_DIVU, da[i], db[i], i == 0);
        read_hilo();
      end
    end
  endtask

  initial begin
    instr_valid_i = 1'b0;
    instr_i       = '0;
    rs_val_i      = '0;
    rt_val_i      = '0;
    arst_n_i      = 1'b0;
    hi_m          = '0;
    lo_m          = '0;
    void'($urandom(41166));
    repeat (2) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    test_reset_idle();
    test_rtype_alu();
    test_itype_alu();
    test_overflow();
    test_multiply();
    test_divide();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- mips_exec.f
+incdir+include
hdl/mips_pkg.sv
hdl/instr_decode.sv
hdl/int_alu.sv
hdl/muldiv_unit.sv
hdl/result_select.sv
hdl/mips_exec_top.sv
testbench/tb_mips_exec.sv

//--- run_sim.sh
#!/bin/sh
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mips_exec \
  -f mips_exec.f -Mdir obj_dir -o tb_mips_exec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mips_exec > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
